// File: tb.f
hdl/core_pkg.sv
hdl/alu.sv
hdl/acc_psw.sv
hdl/fetch_decode.sv
hdl/ram_access.sv
hdl/core_top.sv
test/tb_clock.sv
test/tb_core.sv

// File: Makefile
TOOL     = verilator
FLAGS    = --binary --timing --assert
TOP      = tb_core
FILELIST = tb.f
LOG      = sim.log

.PHONY: sim clean

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "TESTS PASSED" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// File: test/core_cases.txt
// per test: test id, program length, program bytes, ram count, ram addr/data pairs,
// write count, expected write addr/data pairs; a test id of 00 ends the list
// test 1 immediate logic ops
01 18
74 5A F5 30 54 0F F5 31 44 F0 F5 32 64 33 F5 33 F4 F5 34 E4 F5 35 80 FE
00
06 30 5A 31 0A 32 FA 33 C9 34 36 35 00
// test 2 add, addc, subb and carry through rlc/rrc
02 2B
74 F0 24 20 33 F5 40 34 7F 13 F5 41 D3 94 10 33 F5 42 D3 34
01 F5 43 94 90 13 F5 44 D3 C3 33 F5 45 33 F5 46 04 14 14 F5
47 80 FE
00
08 40 21 41 50 42 7E 43 80 44 F8 45 F0 46 E1 47 E0
// test 3 register and direct reads with random valid delay
03 14
E8 2B F5 50 EF 2C 2D F5 51 EA 29 2E F5 52 E5 05 F5 53 80 FE
08 00 13 01 27 02 4C 03 81 04 9E 05 A5 06 F0 07 3D
04 50 94 51 80 52 63 53 A5
// test 4 write then read of the same register
04 0F
74 6B F9 E9 24 01 F5 60 FE EE 04 F5 61 80 FE
02 01 C4 06 5F
04 01 6B 60 6C 06 6C 61 6D
// test 5 sjmp skips a store
05 0D
74 21 F5 70 80 02 F5 71 04 F5 72 80 FE
00
02 70 21 72 22
// end of list
00

// File: test/tb_core.sv
`timescale 1ns/1ps

module tb_core;

	localparam int CASE_WORDS = 1024;
	localparam int DRAIN_CYCLES = 20;

	logic clk;
	logic rst;
	logic run_rst; // per-test reset
	logic dut_rst;
	core_pkg::code_addr_t rom_addr;
	core_pkg::byte_t rom_data;
	core_pkg::byte_t ram_rd_addr;
	core_pkg::byte_t ram_rd_data;
	logic ram_rd_vld;
	logic data_rd_en;
	core_pkg::byte_t ram_wr_addr;
	core_pkg::byte_t ram_wr_data;
	logic data_wr_en;

	core_pkg::byte_t rom [0:65535];
	core_pkg::byte_t ram [0:255];
	core_pkg::byte_t case_mem [0:CASE_WORDS-1];
	core_pkg::byte_t exp_addr [$];
	core_pkg::byte_t exp_data [$];
	core_pkg::code_addr_t rom_addr_q;
	core_pkg::byte_t rd_byte_q;
	core_pkg::byte_t wr_exp_addr;
	core_pkg::byte_t wr_exp_data;
	logic rd_pend;
	logic checking;
	int rd_delay;
	int errors;
	int cycles;
	int limit;
	int pos;
	int test_id;
	int n_tests;
	int n_failed;
	int total_bytes;
	int total_tests;

	assign dut_rst = rst & run_rst;

	tb_clock u_clock (
		.clk (clk),
		.rst (rst)
	);

	core_top DUT (
		.clk         (clk),
		.rst         (dut_rst),
		.rom_addr    (rom_addr),
		.rom_data    (rom_data),
		.ram_rd_addr (ram_rd_addr),
		.ram_rd_data (ram_rd_data),
		.ram_rd_vld  (ram_rd_vld),
		.data_rd_en  (data_rd_en),
		.ram_wr_addr (ram_wr_addr),
		.ram_wr_data (ram_wr_data),
		.data_wr_en  (data_wr_en)
	);

	// registered rom, data follows the address of the previous edge
	always @(posedge clk) begin
		rom_addr_q = rom_addr;
		#1 rom_data = rom[rom_addr_q];
	end

	// read port answers 1 to 3 cycles after the request
	always @(posedge clk) begin
		if (dut_rst && data_rd_en) begin
			rd_pend = 1'b1;
			rd_byte_q = ram[ram_rd_addr]; // ram before a write on the same edge
			rd_delay = $urandom_range(3, 1);
		end
		#1;
		ram_rd_vld = 1'b0;
		if (!dut_rst) begin
			rd_pend = 1'b0;
		end else if (rd_pend) begin
			rd_delay--;
			if (rd_delay == 0) begin
				ram_rd_data = rd_byte_q;
				ram_rd_vld = 1'b1;
				rd_pend = 1'b0;
			end
		end
	end

	// write port, each write checked against the next expected pair
	always @(posedge clk) begin
		if (dut_rst && data_wr_en) begin
			ram[ram_wr_addr] <= ram_wr_data;
			if (checking) begin
				if (exp_addr.size() == 0) begin
					$display("unexpected extra write of %h to address %h at %0t ns",
						ram_wr_data, ram_wr_addr, $time);
					errors++;
				end else begin
					wr_exp_addr = exp_addr.pop_front();
					wr_exp_data = exp_data.pop_front();
					check_wr_addr(ram_wr_addr, wr_exp_addr);
					check_wr_data(ram_wr_data, wr_exp_data);
				end
			end
		end
	end

	always @(posedge clk) begin
		cycles++;
		if (limit > 0 && cycles > limit) begin
			$display("timeout after %0d cycles, expected writes never arrived", cycles);
			$display("TESTS FAILED");
			$finish;
		end
	end

	task automatic check_wr_addr(input core_pkg::byte_t got, input core_pkg::byte_t exp);
		if (got !== exp) begin
			$display("[FAIL] %0t ns ram_wr_addr got %h expected %h", $time, got, exp);
			errors++;
		end
	endtask

	task automatic check_wr_data(input core_pkg::byte_t got, input core_pkg::byte_t exp);
		if (got !== exp) begin
			$display("[FAIL] %0t ns ram_wr_data got %h expected %h", $time, got, exp);
			errors++;
		end
	endtask

	// walks the case list once to size the timeout
	task automatic sum_program_bytes(output int total, output int tests);
		int p;
		int n;
		p = 0;
		total = 0;
		tests = 0;
		while (p < CASE_WORDS - 2 && case_mem[p] != 8'h00) begin
			tests++;
			n = int'(case_mem[p + 1]);
			total += n;
			p += 2 + n;
			n = int'(case_mem[p]);
			p += 1 + 2 * n; // ram pairs
			n = int'(case_mem[p]);
			p += 1 + 2 * n; // expected writes
		end
	endtask

	task automatic load_test();
		int n;
		int i;
		test_id = int'(case_mem[pos]);
		n = int'(case_mem[pos + 1]);
		pos += 2;
		for (i = 0; i < 65536; i++)
			rom[i] = core_pkg::byte_t'(i) ^ core_pkg::byte_t'(i >> 8); // filler, never executed
		for (i = 0; i < n; i++)
			rom[i] = case_mem[pos + i];
		pos += n;
		for (i = 0; i < 256; i++)
			ram[i] = core_pkg::byte_t'(i) ^ 8'hA5;
		n = int'(case_mem[pos]);
		pos++;
		for (i = 0; i < n; i++)
			ram[case_mem[pos + 2 * i]] = case_mem[pos + 2 * i + 1];
		pos += 2 * n;
		n = int'(case_mem[pos]);
		pos++;
		exp_addr.delete();
		exp_data.delete();
		for (i = 0; i < n; i++) begin
			exp_addr.push_back(case_mem[pos + 2 * i]);
			exp_data.push_back(case_mem[pos + 2 * i + 1]);
		end
		pos += 2 * n;
	endtask

	task automatic run_test();
		int errors_before;
		errors_before = errors;
		@(posedge clk);
		#1;
		run_rst = 1'b0;
		checking = 1'b0;
		load_test();
		repeat (2) @(posedge clk);
		#1;
		checking = 1'b1;
		run_rst = 1'b1;
		while (exp_addr.size() > 0)
			@(posedge clk);
		repeat (DRAIN_CYCLES) @(posedge clk); // catch writes past the list
		checking = 1'b0;
		n_tests++;
		if (errors == errors_before) begin
			$display("test %0d passed", test_id);
		end else begin
			n_failed++;
			$display("test %0d failed with %0d errors", test_id, errors - errors_before);
		end
	endtask

	initial begin
		run_rst = 1'b0;
		checking = 1'b0;
		rom_data = 8'h00;
		ram_rd_data = 8'h00;
		ram_rd_vld = 1'b0;
		rd_pend = 1'b0;
		errors = 0;
		cycles = 0;
		limit = 0;
		pos = 0;
		n_tests = 0;
		n_failed = 0;
		void'($urandom(32'h9a44_2517));
		$readmemh("test/core_cases.txt", case_mem);
		sum_program_bytes(total_bytes, total_tests);
		if (total_tests == 0) begin
			$display("no tests found in the cases file");
			$display("TESTS FAILED");
			$finish;
		end else begin
			limit = 16 * total_bytes + 100;
			@(posedge rst);
			while (case_mem[pos] != 8'h00)
				run_test();
			$display("%0d tests run, %0d failed, %0d errors", n_tests, n_failed, errors);
			if (errors == 0)
				$display("TESTS PASSED");
			else
				$display("TESTS FAILED");
			$finish;
		end
	end

endmodule

// File: test/tb_clock.sv
`timescale 1ns/1ps

module tb_clock (
	output logic clk,
	output logic rst
);

	initial clk = 1'b0;
	always #4 clk = ~clk; // 8 ns period

	initial begin
		rst = 1'b0;
		repeat (2) @(posedge clk);
		#1 rst = 1'b1;
	end

endmodule

// File: hdl/core_top.sv
`timescale 1ns/1ps

module core_top #(
	parameter core_pkg::code_addr_t RESET_VECTOR = '0
) (
	input  logic                 clk,
	input  logic                 rst,
	output core_pkg::code_addr_t rom_addr,
	input  core_pkg::byte_t      rom_data,
	output core_pkg::byte_t      ram_rd_addr,
	input  core_pkg::byte_t      ram_rd_data,
	input  logic                 ram_rd_vld,
	output logic                 data_rd_en,
	output core_pkg::byte_t      ram_wr_addr,
	output core_pkg::byte_t      ram_wr_data,
	output logic                 data_wr_en
);

	logic work_en;
	logic rd_req;
	logic wr_req;
	core_pkg::byte_t rd_addr;
	core_pkg::byte_t wr_addr;
	core_pkg::alu_op_t exec_op;
	core_pkg::src_t exec_src;
	core_pkg::byte_t exec_operand;
	core_pkg::byte_t mem_byte;
	core_pkg::byte_t acc;

	fetch_decode #(
		.RESET_VECTOR (RESET_VECTOR)
	) u_fetch_decode (
		.clk          (clk),
		.rst          (rst),
		.work_en      (work_en),
		.rom_addr     (rom_addr),
		.rom_data     (rom_data),
		.rd_req       (rd_req),
		.rd_addr      (rd_addr),
		.exec_op      (exec_op),
		.exec_src     (exec_src),
		.exec_operand (exec_operand),
		.wr_req       (wr_req),
		.wr_addr      (wr_addr)
	);

	ram_access u_ram_access (
		.clk         (clk),
		.rst         (rst),
		.rd_req      (rd_req),
		.rd_addr     (rd_addr),
		.wr_req      (wr_req),
		.wr_addr     (wr_addr),
		.acc         (acc), // write data for mov Rn,A and mov dir,A
		.ram_rd_addr (ram_rd_addr),
		.ram_rd_data (ram_rd_data),
		.ram_rd_vld  (ram_rd_vld),
		.data_rd_en  (data_rd_en),
		.ram_wr_addr (ram_wr_addr),
		.ram_wr_data (ram_wr_data),
		.data_wr_en  (data_wr_en),
		.work_en     (work_en),
		.mem_byte    (mem_byte)
	);

	acc_psw u_acc_psw (
		.clk          (clk),
		.rst          (rst),
		.work_en      (work_en),
		.exec_op      (exec_op),
		.exec_src     (exec_src),
		.exec_operand (exec_operand),
		.mem_byte     (mem_byte),
		.acc          (acc)
	);

endmodule

// File: hdl/ram_access.sv
`timescale 1ns/1ps

module ram_access (
	input  logic            clk,
	input  logic            rst,
	input  logic            rd_req,
	input  core_pkg::byte_t rd_addr,
	input  logic            wr_req,
	input  core_pkg::byte_t wr_addr,
	input  core_pkg::byte_t acc,
	output core_pkg::byte_t ram_rd_addr,
	input  core_pkg::byte_t ram_rd_data,
	input  logic            ram_rd_vld,
	output logic            data_rd_en,
	output core_pkg::byte_t ram_wr_addr,
	output core_pkg::byte_t ram_wr_data,
	output logic            data_wr_en,
	output logic            work_en,
	output core_pkg::byte_t mem_byte
);

	logic ram_wait; // a read is out and its valid has not come
	logic data_same;
	logic same_flag;
	core_pkg::byte_t same_byte;

	// stall only while waiting for the read data
	assign work_en = ~(ram_wait & ~ram_rd_vld);

	assign ram_wr_addr = wr_addr;
	assign ram_wr_data = acc; // accumulator before this cycle's update
	assign data_wr_en = work_en & wr_req;

	// read of the address being written this cycle takes the write byte
	assign data_same = data_wr_en & rd_req & (rd_addr == wr_addr);

	assign ram_rd_addr = rd_addr;
	assign data_rd_en = work_en & rd_req & ~data_same;

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			ram_wait <= 1'b0;
		end else if (work_en) begin
			if (data_rd_en)
				ram_wait <= 1'b1;
			else if (ram_rd_vld)
				ram_wait <= 1'b0;
		end
	end

	always_ff @(posedge clk or negedge rst) begin
		if (!rst)
			same_flag <= 1'b0;
		else if (work_en)
			same_flag <= data_same;
	end

	always_ff @(posedge clk) begin
		if (work_en & data_same)
			same_byte <= ram_wr_data;
	end

	assign mem_byte = same_flag ? same_byte : ram_rd_data;

	// valid only answers a read that was issued earlier
	assert property (@(posedge clk) disable iff (!rst)
		ram_rd_vld |-> ram_wait);

	// one read in flight at a time on the ram port
	assert property (@(posedge clk) disable iff (!rst)
		data_rd_en |=> (!data_rd_en || ram_rd_vld));

endmodule

// File: hdl/fetch_decode.sv
`timescale 1ns/1ps

module fetch_decode #(
	parameter core_pkg::code_addr_t RESET_VECTOR = '0
) (
	input  logic                   clk,
	input  logic                   rst,
	input  logic                   work_en,
	output core_pkg::code_addr_t   rom_addr,
	input  core_pkg::byte_t        rom_data,
	output logic                   rd_req,
	output core_pkg::byte_t        rd_addr,
	output core_pkg::alu_op_t      exec_op,
	output core_pkg::src_t         exec_src,
	output core_pkg::byte_t        exec_operand,
	output logic                   wr_req,
	output core_pkg::byte_t        wr_addr
);

	core_pkg::code_addr_t pc;
	core_pkg::code_addr_t jump_target;
	core_pkg::fetch_state_t state;
	core_pkg::byte_t fetch_byte;
	core_pkg::byte_t rom_hold;
	core_pkg::byte_t opc_q;
	core_pkg::byte_t opcode;
	core_pkg::reg_idx_t rn;
	logic fetch_vld; // rom_data belongs to the current stream
	logic stall_q;
	logic two_byte;
	logic instr_done;
	core_pkg::alu_op_t dec_op;
	core_pkg::src_t dec_src;
	core_pkg::byte_t dec_addr;
	logic dec_rd;
	logic dec_wr;
	logic dec_jump;

	assign rom_addr = pc;

	// the registered rom moves on during a stall, so replay the held byte
	assign fetch_byte = stall_q ? rom_hold : rom_data;

	assign two_byte = fetch_byte inside {core_pkg::OPC_MOV_A_IMM, core_pkg::OPC_ADD_A_IMM,
		core_pkg::OPC_ADDC_A_IMM, core_pkg::OPC_SUBB_A_IMM, core_pkg::OPC_ANL_A_IMM,
		core_pkg::OPC_ORL_A_IMM, core_pkg::OPC_XRL_A_IMM, core_pkg::OPC_MOV_A_DIR,
		core_pkg::OPC_MOV_DIR_A, core_pkg::OPC_SJMP};

	assign instr_done = fetch_vld & ((state == core_pkg::st_operand) | ~two_byte);
	assign opcode = (state == core_pkg::st_operand) ? opc_q : fetch_byte;
	assign rn = opcode[2:0];
	assign jump_target = pc + {{8{fetch_byte[7]}}, fetch_byte}; // pc already past both bytes

	always_comb begin
		dec_op = core_pkg::op_none;
		dec_src = core_pkg::src_imm;
		dec_addr = fetch_byte; // direct address is the operand byte
		dec_rd = 1'b0;
		dec_wr = 1'b0;
		dec_jump = 1'b0;
		if (opcode[7:3] == core_pkg::OPC_ADD_A_RN[7:3]) begin
			dec_op = core_pkg::op_add;
			dec_src = core_pkg::src_mem;
			dec_addr = {5'b00000, rn};
			dec_rd = 1'b1;
		end else if (opcode[7:3] == core_pkg::OPC_MOV_A_RN[7:3]) begin
			dec_op = core_pkg::op_mov;
			dec_src = core_pkg::src_mem;
			dec_addr = {5'b00000, rn};
			dec_rd = 1'b1;
		end else if (opcode[7:3] == core_pkg::OPC_MOV_RN_A[7:3]) begin
			dec_addr = {5'b00000, rn};
			dec_wr = 1'b1;
		end else begin
			case (opcode)
				core_pkg::OPC_NOP: ;
				core_pkg::OPC_MOV_A_IMM:  dec_op = core_pkg::op_mov;
				core_pkg::OPC_ADD_A_IMM:  dec_op = core_pkg::op_add;
				core_pkg::OPC_ADDC_A_IMM: dec_op = core_pkg::op_addc;
				core_pkg::OPC_SUBB_A_IMM: dec_op = core_pkg::op_subb;
				core_pkg::OPC_ANL_A_IMM:  dec_op = core_pkg::op_anl;
				core_pkg::OPC_ORL_A_IMM:  dec_op = core_pkg::op_orl;
				core_pkg::OPC_XRL_A_IMM:  dec_op = core_pkg::op_xrl;
				core_pkg::OPC_MOV_A_DIR: begin
					dec_op = core_pkg::op_mov;
					dec_src = core_pkg::src_mem;
					dec_rd = 1'b1;
				end
				core_pkg::OPC_MOV_DIR_A: dec_wr = 1'b1;
				core_pkg::OPC_INC_A:  dec_op = core_pkg::op_inc;
				core_pkg::OPC_DEC_A:  dec_op = core_pkg::op_dec;
				core_pkg::OPC_CLR_A:  dec_op = core_pkg::op_clr;
				core_pkg::OPC_CPL_A:  dec_op = core_pkg::op_cpl;
				core_pkg::OPC_RL_A:   dec_op = core_pkg::op_rl;
				core_pkg::OPC_RLC_A:  dec_op = core_pkg::op_rlc;
				core_pkg::OPC_RR_A:   dec_op = core_pkg::op_rr;
				core_pkg::OPC_RRC_A:  dec_op = core_pkg::op_rrc;
				core_pkg::OPC_CLR_C:  dec_op = core_pkg::op_clr_c;
				core_pkg::OPC_SETB_C: dec_op = core_pkg::op_setb_c;
				core_pkg::OPC_SJMP:   dec_jump = 1'b1;
				default: ; // unknown opcodes behave as nop
			endcase
		end
	end

	assign rd_req = instr_done & dec_rd;
	assign rd_addr = dec_addr;

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			pc <= RESET_VECTOR;
			state <= core_pkg::st_opcode;
			fetch_vld <= 1'b0;
			stall_q <= 1'b0;
			exec_op <= core_pkg::op_none;
			wr_req <= 1'b0;
		end else begin
			stall_q <= ~work_en;
			if (work_en) begin
				fetch_vld <= ~(instr_done & dec_jump); // drop the byte behind a jump
				pc <= (instr_done & dec_jump) ? jump_target : pc + 16'd1;
				if (fetch_vld & (state == core_pkg::st_opcode) & two_byte)
					state <= core_pkg::st_operand;
				else
					state <= core_pkg::st_opcode;
				exec_op <= instr_done ? dec_op : core_pkg::op_none;
				wr_req <= instr_done & dec_wr;
			end
		end
	end

	always_ff @(posedge clk) begin
		rom_hold <= fetch_byte;
		if (work_en) begin
			if (state == core_pkg::st_opcode)
				opc_q <= fetch_byte;
			exec_src <= dec_src;
			exec_operand <= fetch_byte; // immediate byte
			wr_addr <= dec_addr;
		end
	end

	// an instruction that reads never writes back in its execute bundle
	assert property (@(posedge clk) disable iff (!rst)
		(rd_req && work_en) |=> !wr_req);

endmodule

// File: hdl/acc_psw.sv
`timescale 1ns/1ps

module acc_psw (
	input  logic              clk,
	input  logic              rst,
	input  logic              work_en,
	input  core_pkg::alu_op_t exec_op,
	input  core_pkg::src_t    exec_src,
	input  core_pkg::byte_t   exec_operand,
	input  core_pkg::byte_t   mem_byte,
	output core_pkg::byte_t   acc
);

	core_pkg::byte_t operand;
	core_pkg::byte_t alu_result;
	core_pkg::byte_t psw;
	logic alu_cy;
	logic alu_ac;
	logic alu_ov;
	logic cy;
	logic ac;
	logic ov;
	logic p;
	logic arith; // add, addc, subb

	assign operand = (exec_src == core_pkg::src_mem) ? mem_byte : exec_operand;

	alu u_alu (
		.op     (exec_op),
		.a      (acc),
		.b      (operand),
		.cy_in  (cy),
		.result (alu_result),
		.cy_out (alu_cy),
		.ac_out (alu_ac),
		.ov_out (alu_ov)
	);

	assign arith = exec_op inside {core_pkg::op_add, core_pkg::op_addc, core_pkg::op_subb};

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			acc <= 8'h00;
			cy <= 1'b0;
			ac <= 1'b0;
			ov <= 1'b0;
		end else if (work_en) begin
			acc <= alu_result; // alu passes acc through for non-acc ops
			cy <= alu_cy;
			if (arith) begin
				ac <= alu_ac;
				ov <= alu_ov;
			end
		end
	end

	assign p = ^acc; // even parity, follows acc directly
	assign psw = {cy, ac, 3'b000, ov, 1'b0, p};

	// add sets ac on a low nibble carry and ov on a sign change of same-sign operands
	assert property (@(posedge clk) disable iff (!rst)
		(work_en && exec_op == core_pkg::op_add) |=>
		(psw[6] == (({1'b0, $past(acc[3:0])} + {1'b0, $past(operand[3:0])}) > 5'd15)) &&
		(psw[2] == (($past(acc[7]) == $past(operand[7])) && (acc[7] != $past(acc[7])))));

endmodule

// File: hdl/alu.sv
`timescale 1ns/1ps

module alu (
	input  core_pkg::alu_op_t op,
	input  core_pkg::byte_t   a,
	input  core_pkg::byte_t   b,
	input  logic              cy_in,
	output core_pkg::byte_t   result,
	output logic              cy_out,
	output logic              ac_out,
	output logic              ov_out
);

	logic sub;
	logic add_c;
	core_pkg::byte_t add_b;
	logic [3:0] low;
	logic [3:0] high; // bit 3 is the carry into bit 7
	logic bit_high;
	logic ac_buf;
	logic cy_buf;
	core_pkg::byte_t add_byte;

	always_comb begin
		sub = 1'b0;
		add_b = b;
		add_c = 1'b0; // plain add ignores carry
		case (op)
			core_pkg::op_addc: add_c = cy_in;
			core_pkg::op_subb: begin
				sub = 1'b1;
				add_c = cy_in;
			end
			core_pkg::op_inc: begin
				add_b = 8'h00;
				add_c = 1'b1;
			end
			core_pkg::op_dec: begin
				sub = 1'b1;
				add_b = 8'h00;
				add_c = 1'b1;
			end
			default: ;
		endcase
	end

	// nibble, three bits, then the top bit, so ac and ov fall out of the chain
	assign {ac_buf, low} = sub ? ({1'b0, a[3:0]} - {1'b0, add_b[3:0]} - {4'h0, add_c})
		: ({1'b0, a[3:0]} + {1'b0, add_b[3:0]} + {4'h0, add_c});
	assign high = sub ? ({1'b0, a[6:4]} - {1'b0, add_b[6:4]} - {3'b000, ac_buf})
		: ({1'b0, a[6:4]} + {1'b0, add_b[6:4]} + {3'b000, ac_buf});
	assign {cy_buf, bit_high} = sub ? ({1'b0, a[7]} - {1'b0, add_b[7]} - {1'b0, high[3]})
		: ({1'b0, a[7]} + {1'b0, add_b[7]} + {1'b0, high[3]});
	assign add_byte = {bit_high, high[2:0], low};

	assign ac_out = ac_buf;
	assign ov_out = cy_buf ^ high[3];

	always_comb begin
		result = a;
		cy_out = cy_in;
		case (op)
			core_pkg::op_mov: result = b;
			core_pkg::op_add, core_pkg::op_addc, core_pkg::op_subb: begin
				result = add_byte;
				cy_out = cy_buf;
			end
			core_pkg::op_inc, core_pkg::op_dec: result = add_byte; // flags untouched
			core_pkg::op_anl: result = a & b;
			core_pkg::op_orl: result = a | b;
			core_pkg::op_xrl: result = a ^ b;
			core_pkg::op_clr: result = 8'h00;
			core_pkg::op_cpl: result = ~a;
			core_pkg::op_rl:  result = {a[6:0], a[7]};
			core_pkg::op_rr:  result = {a[0], a[7:1]};
			core_pkg::op_rlc: begin
				result = {a[6:0], cy_in};
				cy_out = a[7];
			end
			core_pkg::op_rrc: begin
				result = {cy_in, a[7:1]};
				cy_out = a[0];
			end
			core_pkg::op_clr_c:  cy_out = 1'b0;
			core_pkg::op_setb_c: cy_out = 1'b1;
			default: ;
		endcase
	end

endmodule

// File: hdl/core_pkg.sv
package core_pkg;

	typedef logic [7:0] byte_t;
	typedef logic [15:0] code_addr_t;
	typedef logic [2:0] reg_idx_t; // Rn index, internal address 0-7

	// operation carried into the execute stage
	typedef enum logic [4:0] {
		op_none,
		op_mov,
		op_add,
		op_addc,
		op_subb,
		op_anl,
		op_orl,
		op_xrl,
		op_inc,
		op_dec,
		op_clr,
		op_cpl,
		op_rl,
		op_rlc,
		op_rr,
		op_rrc,
		op_clr_c,
		op_setb_c
	} alu_op_t;

	typedef enum logic {
		src_imm, // second operand from the code stream
		src_mem  // second operand read from internal data
	} src_t;

	typedef enum logic {
		st_opcode,
		st_operand
	} fetch_state_t;

	localparam byte_t OPC_NOP        = 8'h00;
	localparam byte_t OPC_MOV_A_IMM  = 8'h74;
	localparam byte_t OPC_ADD_A_IMM  = 8'h24;
	localparam byte_t OPC_ADDC_A_IMM = 8'h34;
	localparam byte_t OPC_SUBB_A_IMM = 8'h94;
	localparam byte_t OPC_ANL_A_IMM  = 8'h54;
	localparam byte_t OPC_ORL_A_IMM  = 8'h44;
	localparam byte_t OPC_XRL_A_IMM  = 8'h64;
	localparam byte_t OPC_ADD_A_RN   = 8'h28; // low 3 bits select Rn
	localparam byte_t OPC_MOV_A_RN   = 8'hE8;
	localparam byte_t OPC_MOV_RN_A   = 8'hF8;
	localparam byte_t OPC_MOV_A_DIR  = 8'hE5;
	localparam byte_t OPC_MOV_DIR_A  = 8'hF5;
	localparam byte_t OPC_INC_A      = 8'h04;
	localparam byte_t OPC_DEC_A      = 8'h14;
	localparam byte_t OPC_CLR_A      = 8'hE4;
	localparam byte_t OPC_CPL_A      = 8'hF4;
	localparam byte_t OPC_RL_A       = 8'h23;
	localparam byte_t OPC_RLC_A      = 8'h33;
	localparam byte_t OPC_RR_A       = 8'h03;
	localparam byte_t OPC_RRC_A      = 8'h13;
	localparam byte_t OPC_CLR_C      = 8'hC3;
	localparam byte_t OPC_SETB_C     = 8'hD3;
	localparam byte_t OPC_SJMP       = 8'h80;

endpackage
